//--- include/isr_decoder_consts.svh
`ifndef ISR_DECODER_CONSTS_SVH
`define ISR_DECODER_CONSTS_SVH

// instruction state word layout with the opcode in 15..10
`define ISR_WIDTH     16
`define OPCODE_WIDTH  6
`define REG_IDX_WIDTH 3
`define NUM_REGS      8

// register roles
`define PSW_SLOT      5
`define PC_REG        7
`define SP_REG        6

// queue entries and initial credits on both sides
`define CREDIT_COUNT  2

`endif

//--- verilog/isr_decoder_pkg.sv
`include "isr_decoder_consts.svh"

package isr_decoder_pkg;

    // execute-state codes
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        op_hlt = 6'b000000,
        op_clr = 6'b000100,
        op_asl = 6'b001000, op_asr = 6'b001001, op_rlc = 6'b001010, op_rrc = 6'b001011,
        op_lsl = 6'b001100, op_lsr = 6'b001101, op_rol = 6'b001110, op_ror = 6'b001111,
        op_mov = 6'b010000, op_jmp = 6'b010001, op_ret = 6'b010010, op_rit = 6'b010011,
        op_add = 6'b010100, op_rjp = 6'b010101, op_adc = 6'b010110,
        op_sub = 6'b011000, op_sbc = 6'b011010, op_cmp = 6'b011011,
        op_or  = 6'b100000, op_xor = 6'b100001, op_and = 6'b100010, op_bit = 6'b100011,
        op_jsr = 6'b101100, op_rjs = 6'b101101, op_svc = 6'b101110,
        op_brn = 6'b110000, op_brz = 6'b110001, op_brv = 6'b110010, op_brc = 6'b110011,
        op_rbn = 6'b111000, op_rbz = 6'b111001, op_rbv = 6'b111010, op_rbc = 6'b111011
    } op_e;

    typedef enum logic [1:0] {
        mode_d  = 2'd0,
        mode_i  = 2'd1,
        mode_mi = 2'd2,
        mode_ip = 2'd3
    } addr_mode_e;

    typedef struct packed {
        op_e                       opcode;
        addr_mode_e                f_mode;
        logic [`REG_IDX_WIDTH-1:0] f_value;
        addr_mode_e                t_mode;
        logic [`REG_IDX_WIDTH-1:0] t_value;
    } isr_t;

    typedef struct packed {
        logic if0;
        logic if1;
        logic ff0;
        logic ff1;
        logic ff2;
        logic tf0;
        logic tf1;
        logic ex1;
    } phase_t;

    typedef struct packed {
        logic n;
        logic z;
        logic v;
        logic c;
    } psw_t;

    typedef struct packed {
        isr_t   isr;
        phase_t phase;
        psw_t   psw;
    } decode_req_t;

    typedef struct packed {
        logic asl;
        logic asr;
        logic rlc;
        logic rrc;
        logic lsl;
        logic lsr;
        logic rol;
        logic ror;
        logic clr;
        logic mov;
        logic jump_like;
        logic write_group;
        logic flag_group;
        logic arith_read;
        logic logic_read;
        logic branch_taken;
        logic branch_any;
        logic adc;
        logic sbc;
    } op_group_t;

    typedef struct packed {
        logic [`NUM_REGS-1:0] src_read;
        logic [`NUM_REGS-1:0] dst_write;
        logic                 sma;
        logic                 smd;
        logic                 sb0;
        logic                 mda;
        logic                 b0b;
    } reg_sel_t;

    typedef struct packed {
        logic als;
        logic alu_x;
        logic alu_y;
        logic alu_z;
        logic alu_u;
        logic alu_v;
        logic shs;
        logic sft_a;
        logic sft_b;
        logic sft_c;
        logic sft_d;
        logic sft_e;
        logic sft_r;
        logic sft_l;
    } alu_ctrl_t;

    typedef struct packed {
        reg_sel_t  sel;
        alu_ctrl_t alu;
        logic      f_is_d;
        logic      t_is_d;
    } ctrl_word_t;

endpackage

//--- verilog/isr_field_decoder.sv
`timescale 1ns/1ps

module isr_field_decoder
    import isr_decoder_pkg::*;
(
    input  decode_req_t req,
    output op_group_t   ops,
    output logic        f_is_d,
    output logic        t_is_d
);

    op_e  opcode;
    logic is_shift;
    logic is_arith;
    logic is_logic;
    logic taken;

    assign opcode   = req.isr.opcode;
    assign is_shift = opcode inside {op_asl, op_asr, op_rlc, op_rrc,
                                     op_lsl, op_lsr, op_rol, op_ror};
    assign is_arith = opcode inside {op_add, op_adc, op_rjp, op_sub, op_sbc, op_cmp};
    assign is_logic = opcode inside {op_or, op_xor, op_and, op_bit};

    assign f_is_d = (req.isr.f_mode == mode_d);
    assign t_is_d = (req.isr.t_mode == mode_d);

    // plain and relative branches test the same flag
    always_comb begin
        case (opcode)
            op_brn, op_rbn: taken = req.psw.n;
            op_brz, op_rbz: taken = req.psw.z;
            op_brv, op_rbv: taken = req.psw.v;
            op_brc, op_rbc: taken = req.psw.c;
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        ops.asl          = (opcode == op_asl);
        ops.asr          = (opcode == op_asr);
        ops.rlc          = (opcode == op_rlc);
        ops.rrc          = (opcode == op_rrc);
        ops.lsl          = (opcode == op_lsl);
        ops.lsr          = (opcode == op_lsr);
        ops.rol          = (opcode == op_rol);
        ops.ror          = (opcode == op_ror);
        ops.clr          = (opcode == op_clr);
        ops.mov          = (opcode == op_mov);
        ops.adc          = (opcode == op_adc);
        ops.sbc          = (opcode == op_sbc);
        ops.arith_read   = is_arith;
        ops.logic_read   = is_logic;
        ops.jump_like    = opcode inside {op_jmp, op_ret, op_rit, op_jsr, op_rjs, op_svc};
        ops.branch_any   = opcode inside {op_brn, op_brz, op_brv, op_brc,
                                          op_rbn, op_rbz, op_rbv, op_rbc};
        ops.branch_taken = taken;
        // cmp and bit only touch flags while rjp leaves them alone
        ops.write_group  = (opcode == op_clr) || is_shift || (opcode == op_mov)
                           || (is_arith && opcode != op_cmp) || (is_logic && opcode != op_bit);
        ops.flag_group   = (opcode == op_clr) || is_shift || (opcode == op_mov)
                           || (is_arith && opcode != op_rjp) || is_logic;
    end

endmodule

//--- verilog/reg_select_decoder.sv
`timescale 1ns/1ps

`include "isr_decoder_consts.svh"

module reg_select_decoder
    import isr_decoder_pkg::*;
(
    input  decode_req_t req,
    input  op_group_t   ops,
    output reg_sel_t    sel
);

    phase_t phase;
    isr_t   isr;
    logic   any_shift;
    logic   f_ip;
    logic   t_ip;
    logic   t_d;
    logic   sp_read;
    logic   pc_read;
    logic   pc_load;
    logic   call_ex;

    assign phase     = req.phase;
    assign isr       = req.isr;
    assign any_shift = ops.asl | ops.asr | ops.rlc | ops.rrc
                     | ops.lsl | ops.lsr | ops.rol | ops.ror;

    assign f_ip = (isr.f_mode == mode_ip);
    assign t_ip = (isr.t_mode == mode_ip);
    assign t_d  = (isr.t_mode == mode_d);

    // return paths pop through the stack pointer
    assign sp_read = isr.opcode inside {op_ret, op_rit};
    assign pc_read = phase.if0 | phase.if1 | (phase.ex1 & (isr.opcode == op_rjs));
    assign call_ex = phase.ex1 & (isr.opcode inside {op_jsr, op_rjs, op_svc});
    assign pc_load = phase.if1 | (isr.opcode inside {op_jmp, op_ret, op_rit})
                   | ops.branch_taken | call_ex;

    always_comb begin
        logic [`REG_IDX_WIDTH-1:0] idx;
        logic                      f_hit;
        logic                      t_hit;
        for (int n = 0; n < `NUM_REGS; n++) begin
            idx   = `REG_IDX_WIDTH'(n);
            f_hit = (phase.ff0 || (phase.ff1 && f_ip)) && (isr.f_value == idx);
            t_hit = isr.t_value == idx;
            sel.src_read[n]  = f_hit || (phase.tf0 && t_hit) || (phase.tf1 && t_ip && t_hit);
            sel.dst_write[n] = f_hit || (phase.tf1 && t_ip && t_hit)
                               || (ops.write_group && t_d && t_hit);
        end
        sel.src_read[`SP_REG]  = sel.src_read[`SP_REG] | sp_read;
        sel.src_read[`PC_REG]  = sel.src_read[`PC_REG] | pc_read;
        sel.dst_write[`PC_REG] = sel.dst_write[`PC_REG] | pc_load;
        // this slot writes the status word and never register 5
        sel.dst_write[`PSW_SLOT] = ops.flag_group;

        sel.sma = phase.if0 | phase.ff0 | phase.tf0;
        sel.smd = phase.if0 | phase.ff0 | phase.tf0 | ops.write_group
                | (isr.opcode inside {op_jsr, op_rjs, op_svc});
        sel.sb0 = phase.ff2;
        sel.mda = phase.ff2 | any_shift | ops.arith_read | ops.logic_read
                | (isr.opcode inside {op_rbn, op_rbz, op_rbv, op_rbc});
        sel.b0b = ops.mov | ops.arith_read | ops.logic_read | ops.jump_like
                | ops.branch_any | phase.ex1;
    end

endmodule

//--- verilog/alu_control_decoder.sv
`timescale 1ns/1ps

module alu_control_decoder
    import isr_decoder_pkg::*;
(
    input  decode_req_t req,
    input  op_group_t   ops,
    output alu_ctrl_t   alu
);

    op_e  opcode;
    logic any_shift;
    logic pass;

    assign opcode    = req.isr.opcode;
    assign any_shift = ops.asl | ops.asr | ops.rlc | ops.rrc
                     | ops.lsl | ops.lsr | ops.rol | ops.ror;

    // alu passes its operand through on every phase step and plain data move
    assign pass = (|req.phase) | ops.mov | ops.arith_read | ops.jump_like | ops.branch_any;

    always_comb begin
        alu.als   = pass | ops.clr | ops.logic_read;
        alu.alu_x = (req.phase.ff0 && req.isr.f_mode == mode_mi)
                    || (opcode inside {op_sub, op_sbc, op_cmp});
        alu.alu_y = pass;
        alu.alu_z = (opcode == op_or);
        // carry in for increments and subtracts
        alu.alu_u = req.phase.if1 | req.phase.ff1 | req.phase.tf1
                  | (opcode == op_sub) | (opcode == op_cmp)
                  | (ops.adc & req.psw.c) | (ops.sbc & ~req.psw.c);
        alu.alu_v = pass | (opcode == op_xor);

        alu.shs   = any_shift;
        alu.sft_a = ops.asl | ops.asr;
        alu.sft_b = ops.rol;
        alu.sft_c = ops.lsl | ops.rol | ops.rlc;
        alu.sft_d = ops.ror;
        alu.sft_e = ops.rlc | ops.rrc;
        alu.sft_r = ops.asr | ops.ror | ops.rrc;
        alu.sft_l = ops.asl | ops.lsl | ops.rol | ops.rlc;
    end

endmodule

//--- verilog/ctrl_word_queue.sv
`timescale 1ns/1ps

`include "isr_decoder_consts.svh"

module ctrl_word_queue
    import isr_decoder_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       req_valid,
    input  reg_sel_t   sel,
    input  alu_ctrl_t  alu,
    input  logic       f_is_d,
    input  logic       t_is_d,
    input  logic       credit_return,
    output logic       ctrl_valid,
    output ctrl_word_t ctrl,
    output logic       req_credit
);

    localparam int DEPTH = `CREDIT_COUNT;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    ctrl_word_t       mem [DEPTH];
    ctrl_word_t       word_in;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] entry_count;
    logic [CNT_W-1:0] entry_count_next;
    logic [CNT_W-1:0] down_credits;
    logic [CNT_W-1:0] down_credits_next;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign word_in = '{sel: sel, alu: alu, f_is_d: f_is_d, t_is_d: t_is_d};

    // head leaves whenever it is presented and its slot goes back upstream at once
    assign pop        = ctrl_valid;
    assign req_credit = ctrl_valid;
    assign ctrl       = mem[rd_ptr];

    always_comb begin
        entry_count_next = entry_count;
        if (req_valid && !pop) begin
            entry_count_next = entry_count + 1'b1;
        end else if (!req_valid && pop) begin
            entry_count_next = entry_count - 1'b1;
        end
    end

    always_comb begin
        down_credits_next = down_credits;
        if (credit_return && !pop) begin
            down_credits_next = down_credits + 1'b1;
        end else if (!credit_return && pop) begin
            down_credits_next = down_credits - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            entry_count  <= '0;
            down_credits <= CNT_W'(DEPTH);
            ctrl_valid   <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            entry_count  <= entry_count_next;
            down_credits <= down_credits_next;
            ctrl_valid   <= (entry_count_next != '0) && (down_credits_next != '0);
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            mem[wr_ptr] <= word_in;
        end
    end

endmodule

//--- verilog/isr_decoder_top.sv
`timescale 1ns/1ps

module isr_decoder_top
    import isr_decoder_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  decode_req_t req,
    input  logic        credit_return,
    output logic        ctrl_valid,
    output ctrl_word_t  ctrl,
    output logic        req_credit
);

    op_group_t ops;
    reg_sel_t  sel;
    alu_ctrl_t alu;
    logic      f_is_d;
    logic      t_is_d;

    isr_field_decoder i_field_decoder (
        .req    (req),
        .ops    (ops),
        .f_is_d (f_is_d),
        .t_is_d (t_is_d)
    );

    // register and alu decoding run side by side
    reg_select_decoder i_reg_select (
        .req (req),
        .ops (ops),
        .sel (sel)
    );

    alu_control_decoder i_alu_control (
        .req (req),
        .ops (ops),
        .alu (alu)
    );

    ctrl_word_queue i_queue (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .sel           (sel),
        .alu           (alu),
        .f_is_d        (f_is_d),
        .t_is_d        (t_is_d),
        .credit_return (credit_return),
        .ctrl_valid    (ctrl_valid),
        .ctrl          (ctrl),
        .req_credit    (req_credit)
    );

endmodule

//--- tests/isr_decoder_properties.sv
`timescale 1ns/1ps

module isr_decoder_properties #(
    parameter int DEPTH = 2,
    parameter int CNT_W = 2
) (
    input logic             clk,
    input logic             reset,
    input logic             req_valid,
    input logic             credit_return,
    input logic             ctrl_valid,
    input logic             req_credit,
    input logic [CNT_W-1:0] entry_count
);

    int fail_count = 0;
    int held_credits;

    // downstream credits as the consumer hands them out and gets them back
    always @(posedge clk) begin
        if (reset) begin
            held_credits <= DEPTH;
        end else begin
            held_credits <= held_credits + (credit_return ? 1 : 0) - (ctrl_valid ? 1 : 0);
        end
    end

    // a word only goes out against a held downstream credit
    ctrl_needs_credit: assert property (@(posedge clk) disable iff (reset)
        ctrl_valid |-> (held_credits > 0))
        else begin
            fail_count++;
            $error("ctrl_valid high while no downstream credit is held");
        end

    no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        req_valid |-> (entry_count < CNT_W'(DEPTH)))
        else begin
            fail_count++;
            $error("req_valid arrived while the queue was full");
        end

    quiet_in_reset: assert property (@(posedge clk)
        reset |=> (!ctrl_valid && !req_credit))
        else begin
            fail_count++;
            $error("ctrl_valid or req_credit high during reset");
        end

endmodule

//--- tests/isr_decoder_checker.sv
`timescale 1ns/1ps

`include "isr_decoder_consts.svh"

module isr_decoder_checker
    import isr_decoder_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        req_valid,
    input  decode_req_t req,
    input  logic [95:0] test_name,
    input  logic        ctrl_valid,
    input  ctrl_word_t  ctrl,
    input  logic        req_credit,
    input  logic        credit_return,
    output int          done_count,
    output int          err_count
);

    ctrl_word_t  exp_q[$];
    logic [95:0] name_q[$];
    ctrl_word_t  exp_w;
    logic [95:0] exp_name;
    int          issued;
    int          returned;
    logic        word_bad;

    initial begin
        done_count = 0;
        err_count  = 0;
        issued     = 0;
        returned   = 0;
    end

    // reference decode, written from the control equations
    function automatic ctrl_word_t model_word(input decode_req_t r);
        ctrl_word_t w;
        op_e        op;
        logic       shift;
        logic       wr_grp;
        logic       fl_grp;
        logic       jumpy;
        logic       branch;
        logic       taken;
        logic       pass;
        logic       f_ip;
        logic       t_ip;
        op     = r.isr.opcode;
        shift  = op inside {op_asl, op_asr, op_rlc, op_rrc, op_lsl, op_lsr, op_rol, op_ror};
        wr_grp = shift || (op inside {op_clr, op_mov, op_add, op_adc, op_rjp, op_sub,
                                      op_sbc, op_or, op_xor, op_and});
        fl_grp = shift || (op inside {op_clr, op_mov, op_add, op_adc, op_sub, op_sbc,
                                      op_cmp, op_or, op_xor, op_and, op_bit});
        jumpy  = op inside {op_jmp, op_ret, op_rit, op_jsr, op_rjs, op_svc};
        branch = op inside {op_brn, op_brz, op_brv, op_brc, op_rbn, op_rbz, op_rbv, op_rbc};
        taken  = ((op inside {op_brn, op_rbn}) && r.psw.n) || ((op inside {op_brz, op_rbz}) && r.psw.z)
              || ((op inside {op_brv, op_rbv}) && r.psw.v) || ((op inside {op_brc, op_rbc}) && r.psw.c);
        pass   = (|r.phase) || (op inside {op_mov, op_add, op_adc, op_rjp, op_sub, op_sbc, op_cmp})
              || jumpy || branch;
        f_ip   = (r.isr.f_mode == mode_ip);
        t_ip   = (r.isr.t_mode == mode_ip);
        w = '0;
        for (int n = 0; n < `NUM_REGS; n++) begin
            w.sel.src_read[n] = (r.phase.ff0 && r.isr.f_value == n)
                || (r.phase.ff1 && f_ip && r.isr.f_value == n)
                || (r.phase.tf0 && r.isr.t_value == n)
                || (r.phase.tf1 && t_ip && r.isr.t_value == n);
            w.sel.dst_write[n] = (r.phase.ff0 && r.isr.f_value == n)
                || (r.phase.ff1 && f_ip && r.isr.f_value == n)
                || (r.phase.tf1 && t_ip && r.isr.t_value == n)
                || (wr_grp && r.isr.t_mode == mode_d && r.isr.t_value == n);
        end
        w.sel.src_read[`SP_REG] |= op inside {op_ret, op_rit};
        w.sel.src_read[`PC_REG] |= r.phase.if0 || r.phase.if1 || (r.phase.ex1 && op == op_rjs);
        w.sel.dst_write[`PC_REG] |= r.phase.if1 || (op inside {op_jmp, op_ret, op_rit}) || taken
            || (r.phase.ex1 && (op inside {op_jsr, op_rjs, op_svc}));
        w.sel.dst_write[`PSW_SLOT] = fl_grp;
        w.sel.sma = r.phase.if0 || r.phase.ff0 || r.phase.tf0;
        w.sel.smd = w.sel.sma || wr_grp || (op inside {op_jsr, op_rjs, op_svc});
        w.sel.sb0 = r.phase.ff2;
        w.sel.mda = r.phase.ff2 || shift || (op inside {op_add, op_adc, op_rjp, op_sub, op_sbc,
            op_cmp, op_or, op_xor, op_and, op_bit, op_rbn, op_rbz, op_rbv, op_rbc});
        w.sel.b0b = (op inside {op_mov, op_add, op_adc, op_rjp, op_sub, op_sbc, op_cmp, op_or,
            op_xor, op_and, op_bit}) || jumpy || branch || r.phase.ex1;
        w.alu.als   = pass || (op inside {op_clr, op_or, op_xor, op_and, op_bit});
        w.alu.alu_x = (r.phase.ff0 && r.isr.f_mode == mode_mi) || (op inside {op_sub, op_sbc, op_cmp});
        w.alu.alu_y = pass;
        w.alu.alu_z = (op == op_or);
        w.alu.alu_u = r.phase.if1 || r.phase.ff1 || r.phase.tf1 || (op inside {op_sub, op_cmp})
            || (op == op_adc && r.psw.c) || (op == op_sbc && !r.psw.c);
        w.alu.alu_v = pass || (op == op_xor);
        w.alu.shs   = shift;
        w.alu.sft_a = op inside {op_asl, op_asr};
        w.alu.sft_b = (op == op_rol);
        w.alu.sft_c = op inside {op_lsl, op_rol, op_rlc};
        w.alu.sft_d = (op == op_ror);
        w.alu.sft_e = op inside {op_rlc, op_rrc};
        w.alu.sft_r = op inside {op_asr, op_ror, op_rrc};
        w.alu.sft_l = op inside {op_asl, op_lsl, op_rol, op_rlc};
        w.f_is_d = (r.isr.f_mode == mode_d);
        w.t_is_d = (r.isr.t_mode == mode_d);
        return w;
    endfunction

    task automatic check_field(input string name, input logic [7:0] exp_v,
                               input logic [7:0] act_v);
        if (exp_v !== act_v) begin
            $display("ERR %0t %s expected %h actual %h", $time, name, exp_v, act_v);
            err_count++;
            word_bad = 1'b1;
        end
    endtask

    task automatic compare_word(input ctrl_word_t e);
        word_bad = 1'b0;
        check_field("ctrl.sel.src_read", e.sel.src_read, ctrl.sel.src_read);
        check_field("ctrl.sel.dst_write", e.sel.dst_write, ctrl.sel.dst_write);
        check_field("ctrl.sel.sma", e.sel.sma, ctrl.sel.sma);
        check_field("ctrl.sel.smd", e.sel.smd, ctrl.sel.smd);
        check_field("ctrl.sel.sb0", e.sel.sb0, ctrl.sel.sb0);
        check_field("ctrl.sel.mda", e.sel.mda, ctrl.sel.mda);
        check_field("ctrl.sel.b0b", e.sel.b0b, ctrl.sel.b0b);
        check_field("ctrl.alu.als", e.alu.als, ctrl.alu.als);
        check_field("ctrl.alu.alu_x", e.alu.alu_x, ctrl.alu.alu_x);
        check_field("ctrl.alu.alu_y", e.alu.alu_y, ctrl.alu.alu_y);
        check_field("ctrl.alu.alu_z", e.alu.alu_z, ctrl.alu.alu_z);
        check_field("ctrl.alu.alu_u", e.alu.alu_u, ctrl.alu.alu_u);
        check_field("ctrl.alu.alu_v", e.alu.alu_v, ctrl.alu.alu_v);
        check_field("ctrl.alu.shs", e.alu.shs, ctrl.alu.shs);
        check_field("ctrl.alu.sft_a", e.alu.sft_a, ctrl.alu.sft_a);
        check_field("ctrl.alu.sft_b", e.alu.sft_b, ctrl.alu.sft_b);
        check_field("ctrl.alu.sft_c", e.alu.sft_c, ctrl.alu.sft_c);
        check_field("ctrl.alu.sft_d", e.alu.sft_d, ctrl.alu.sft_d);
        check_field("ctrl.alu.sft_e", e.alu.sft_e, ctrl.alu.sft_e);
        check_field("ctrl.alu.sft_r", e.alu.sft_r, ctrl.alu.sft_r);
        check_field("ctrl.alu.sft_l", e.alu.sft_l, ctrl.alu.sft_l);
        check_field("ctrl.f_is_d", e.f_is_d, ctrl.f_is_d);
        check_field("ctrl.t_is_d", e.t_is_d, ctrl.t_is_d);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            name_q.delete();
        end else begin
            if (ctrl_valid) begin
                issued++;
                if (issued > `CREDIT_COUNT + returned) begin
                    $display("control word %0d went out without a downstream credit", issued);
                    err_count++;
                end
                if (exp_q.size() == 0) begin
                    $display("ctrl_valid at %0t with no request outstanding", $time);
                    err_count++;
                end else begin
                    exp_w    = exp_q.pop_front();
                    exp_name = name_q.pop_front();
                    compare_word(exp_w);
                    done_count++;
                    $display("test %0d %0s: %s", done_count, exp_name,
                             word_bad ? "MISMATCH" : "ok");
                end
            end
            if (req_credit !== ctrl_valid) begin
                $display("req_credit at %0t does not line up with ctrl_valid", $time);
                err_count++;
            end
            if (credit_return) begin
                returned++;
            end
            if (req_valid) begin
                exp_q.push_back(model_word(req));
                name_q.push_back(test_name);
            end
        end
    end

endmodule

//--- tests/isr_decoder_tb.sv
`timescale 1ns/1ps

`include "isr_decoder_consts.svh"

module isr_decoder_tb
    import isr_decoder_pkg::*;
();

    typedef struct packed {
        decode_req_t req;
        logic [95:0] name;
    } stim_t;

    logic        clk;
    logic        reset = 1'b1;
    logic        req_valid = 1'b0;
    decode_req_t req = '0;
    logic        credit_return = 1'b0;
    logic [95:0] test_name = '0;
    logic        ctrl_valid;
    ctrl_word_t  ctrl;
    logic        req_credit;

    stim_t       stim_table[$];
    int          num_entries = 0;
    logic        table_ready = 1'b0;
    int          up_credits = `CREDIT_COUNT;
    int          sent_count = 0;
    int          send_limit = 0;
    int          owed = 0;
    logic        eager_return = 1'b0;
    int          cycle_count = 0;
    int          start_cycle;
    int          elapsed;
    int          credit_errors = 0;
    int          stream_errors = 0;
    int          done_count;
    int          err_count;

    isr_decoder_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .credit_return (credit_return),
        .ctrl_valid    (ctrl_valid),
        .ctrl          (ctrl),
        .req_credit    (req_credit)
    );

    isr_decoder_checker i_checker (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .req           (req),
        .test_name     (test_name),
        .ctrl_valid    (ctrl_valid),
        .ctrl          (ctrl),
        .req_credit    (req_credit),
        .credit_return (credit_return),
        .done_count    (done_count),
        .err_count     (err_count)
    );

    bind ctrl_word_queue isr_decoder_properties #(
        .DEPTH (DEPTH),
        .CNT_W (CNT_W)
    ) i_props (
        .clk           (clk),
        .reset         (reset),
        .req_valid     (req_valid),
        .credit_return (credit_return),
        .ctrl_valid    (ctrl_valid),
        .req_credit    (req_credit),
        .entry_count   (entry_count)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    task automatic add_stim(input isr_t isr, input phase_t ph, input psw_t ps,
                            input logic [95:0] name);
        stim_t s;
        s.req.isr   = isr;
        s.req.phase = ph;
        s.req.psw   = ps;
        s.name      = name;
        stim_table.push_back(s);
    endtask

    task automatic build_table();
        isr_t        isr;
        phase_t      ph;
        psw_t        ps;
        op_e         op;
        logic [95:0] nm;
        logic [3:0]  flag;
        op_e         br_ops[8] = '{op_brn, op_brz, op_brv, op_brc,
                                   op_rbn, op_rbz, op_rbv, op_rbc};
        // operand phases over every mode and register index
        for (int p = 0; p < 4; p++) begin
            for (int m = 0; m < 4; m++) begin
                for (int v = 0; v < `NUM_REGS; v++) begin
                    isr = 16'($urandom);
                    ps  = 4'($urandom);
                    ph  = '0;
                    case (p)
                        0: begin ph.ff0 = 1'b1; nm = "ff0_operand"; end
                        1: begin ph.ff1 = 1'b1; nm = "ff1_operand"; end
                        2: begin ph.tf0 = 1'b1; nm = "tf0_operand"; end
                        default: begin ph.tf1 = 1'b1; nm = "tf1_operand"; end
                    endcase
                    if (p < 2) begin
                        isr.f_mode  = addr_mode_e'(m);
                        isr.f_value = 3'(v);
                    end else begin
                        isr.t_mode  = addr_mode_e'(m);
                        isr.t_value = 3'(v);
                    end
                    add_stim(isr, ph, ps, nm);
                end
            end
        end
        // every opcode in the execute state with carry clear and set and again in ex1
        op = op.first();
        do begin
            isr        = 16'($urandom);
            isr.opcode = op;
            add_stim(isr, '0, 4'h0, "exec_psw_lo");
            add_stim(isr, '0, 4'hf, "exec_psw_hi");
            ph     = '0;
            ph.ex1 = 1'b1;
            add_stim(isr, ph, 4'($urandom), "exec_ex1");
            op = op.next();
        end while (op != op.first());
        // branch flag order is n, z, v, c
        for (int b = 0; b < 8; b++) begin
            isr        = 16'($urandom);
            isr.opcode = br_ops[b];
            flag       = 4'b1000 >> (b % 4);
            add_stim(isr, '0, flag, "branch_flag1");
            add_stim(isr, '0, ~flag, "branch_flag0");
        end
        for (int q = 0; q < 3; q++) begin
            for (int k = 0; k < 4; k++) begin
                isr = 16'($urandom);
                ph  = '0;
                case (q)
                    0: begin ph.if0 = 1'b1; nm = "fetch_if0"; end
                    1: begin ph.if1 = 1'b1; nm = "fetch_if1"; end
                    default: begin ph.ff2 = 1'b1; nm = "fetch_ff2"; end
                endcase
                add_stim(isr, ph, 4'($urandom), nm);
            end
        end
    endtask

    // upstream sends a request only while it holds a credit
    always @(posedge clk) begin
        int avail;
        if (reset) begin
            up_credits <= `CREDIT_COUNT;
            req_valid  <= 1'b0;
        end else begin
            avail = up_credits + (req_credit ? 1 : 0);
            if (avail > `CREDIT_COUNT) begin
                $display("req_credit returned more upstream credits than were spent");
                credit_errors++;
            end
            if (sent_count < send_limit && avail > 0) begin
                req_valid  <= 1'b1;
                req        <= stim_table[sent_count % num_entries].req;
                test_name  <= stim_table[sent_count % num_entries].name;
                sent_count <= sent_count + 1;
                up_credits <= avail - 1;
            end else begin
                req_valid  <= 1'b0;
                up_credits <= avail;
            end
        end
    end

    // consumer gives one credit back per word received
    always @(posedge clk) begin
        int owed_now;
        if (reset) begin
            credit_return <= 1'b0;
            owed          <= 0;
        end else begin
            owed_now = owed + (ctrl_valid ? 1 : 0);
            if (owed_now > 0 && (eager_return || $urandom_range(1) == 1)) begin
                credit_return <= 1'b1;
                owed          <= owed_now - 1;
            end else begin
                credit_return <= 1'b0;
                owed          <= owed_now;
            end
        end
    end

    initial begin
        wait (table_ready);
        repeat (num_entries * 40) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d words seen",
                 num_entries * 40, done_count, 2 * num_entries);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(92));
        build_table();
        num_entries = stim_table.size();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        reset      <= 1'b0;
        send_limit <= num_entries;
        // first pass with credits held back at random
        wait (done_count == num_entries);
        @(posedge clk);
        eager_return <= 1'b1;
        send_limit   <= 2 * num_entries;
        start_cycle = cycle_count;
        wait (done_count == 2 * num_entries);
        elapsed = cycle_count - start_cycle;
        if (elapsed > num_entries + 8) begin
            $display("stream with prompt credit returns stalled, %0d cycles for %0d words",
                     elapsed, num_entries);
            stream_errors++;
        end
        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d checker errors, %0d assertion failures, %0d credit errors",
                 done_count, err_count, i_dut.i_queue.i_props.fail_count,
                 credit_errors + stream_errors);
        if (err_count == 0 && i_dut.i_queue.i_props.fail_count == 0 && credit_errors == 0
            && stream_errors == 0 && done_count == 2 * num_entries) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
verilog/isr_decoder_pkg.sv
verilog/isr_field_decoder.sv
verilog/reg_select_decoder.sv
verilog/alu_control_decoder.sv
verilog/ctrl_word_queue.sv
verilog/isr_decoder_top.sv
tests/isr_decoder_properties.sv
tests/isr_decoder_checker.sv
tests/isr_decoder_tb.sv

//--- Bender.yml
package:
  name: isr_decoder

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/isr_decoder_pkg.sv
      - verilog/isr_field_decoder.sv
      - verilog/reg_select_decoder.sv
      - verilog/alu_control_decoder.sv
      - verilog/ctrl_word_queue.sv
      - verilog/isr_decoder_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - tests/isr_decoder_properties.sv
      - tests/isr_decoder_checker.sv
      - tests/isr_decoder_tb.sv
